// ==== lsu_core.f ====
source/lsu_pkg.sv
source/lsu_agu.sv
source/lsu_req_fifo.sv
source/lsu_mem_unit.sv
source/lsu_top.sv
dv/lsu_top_assert.sv
dv/lsu_tb.sv

// ==== Makefile ====
# Verilator build and run for the load/store unit testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = lsu_tb
FILELIST = lsu_core.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -q ">>> PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/lsu_tb.sv ====
/*
  Directed testbench for the load/store unit.
  Drives requests into lsu_top, predicts each response from a reference
  copy of the data memory and checks the responses in issue order.
  Stops at the first mismatch or timeout.
*/

`timescale 1ns/1ps

module lsu_tb;
  import lsu_pkg::*;

  localparam int unsigned MEM_WORDS   = DEFAULT_MEM_WORDS;
  localparam int unsigned FIFO_DEPTH  = DEFAULT_FIFO_DEPTH;
  localparam int unsigned SEED        = 85776;
  localparam int          HALF_PERIOD = 20;
  localparam int          TIMEOUT     = 50;
  localparam int unsigned MAX_BURST   = 12;

  logic      clk_i;
  logic      rst_ni;
  logic      req_valid_i;
  op_t       req_op_i;
  addr_t     req_base_i;
  xlen_t     req_imm_i;
  xlen_t     req_wdata_i;
  trans_id_t req_trans_id_i;
  logic      req_ready_o;
  logic      resp_valid_o;
  trans_id_t resp_trans_id_o;
  xlen_t     resp_rdata_o;
  logic      resp_is_store_o;
  logic      resp_ex_valid_o;
  cause_t    resp_ex_cause_o;
  logic      resp_ready_i;

  // reference memory and expected responses, oldest first
  xlen_t     ref_mem [MEM_WORDS];
  trans_id_t exp_id_q[$];
  xlen_t     exp_rdata_q[$];
  logic      exp_store_q[$];
  logic      exp_ex_q[$];
  cause_t    exp_cause_q[$];

  lsu_top #(
    .MEM_WORDS  (MEM_WORDS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_op_i        (req_op_i),
    .req_base_i      (req_base_i),
    .req_imm_i       (req_imm_i),
    .req_wdata_i     (req_wdata_i),
    .req_trans_id_i  (req_trans_id_i),
    .req_ready_o     (req_ready_o),
    .resp_valid_o    (resp_valid_o),
    .resp_trans_id_o (resp_trans_id_o),
    .resp_rdata_o    (resp_rdata_o),
    .resp_is_store_o (resp_is_store_o),
    .resp_ex_valid_o (resp_ex_valid_o),
    .resp_ex_cause_o (resp_ex_cause_o),
    .resp_ready_i    (resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #HALF_PERIOD clk_i = ~clk_i;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_id(input string name, input trans_id_t exp, input trans_id_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act));
    end
  endtask

  task automatic check_cause(input string name, input cause_t exp, input cause_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  // --------------------
  // reference model
  // --------------------
  task automatic predict(input op_t op, input addr_t addr, input xlen_t wdata,
                         input trans_id_t id);
    int unsigned size;
    int unsigned off;
    int unsigned idx;
    logic        store;
    logic        mis;
    logic        fault;
    xlen_t       rdata;
    xlen_t       word;
    cause_t      cause;
    store = (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    case (op)
      OP_LB, OP_LBU, OP_SB: size = 1;
      OP_LH, OP_LHU, OP_SH: size = 2;
      default:              size = 4;
    endcase
    off   = addr % 4;
    idx   = addr / 4;
    mis   = (addr % size) != 0;
    fault = idx >= MEM_WORDS;
    rdata = '0;
    cause = mis ? (store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED)
                : (store ? CAUSE_ST_ACCESS_FAULT : CAUSE_LD_ACCESS_FAULT);
    if (!(mis || fault)) begin
      if (store) begin
        for (int unsigned b = 0; b < size; b++) begin
          ref_mem[idx][8*(off+b) +: 8] = wdata[8*b +: 8];
        end
      end else begin
        word = ref_mem[idx];
        for (int unsigned b = 0; b < size; b++) begin
          rdata[8*b +: 8] = word[8*(off+b) +: 8];
        end
        // sign extension for the signed sub-word loads
        if ((op == OP_LB) && rdata[7]) begin
          rdata[31:8] = '1;
        end
        if ((op == OP_LH) && rdata[15]) begin
          rdata[31:16] = '1;
        end
      end
    end
    exp_id_q.push_back(id);
    exp_rdata_q.push_back(rdata);
    exp_store_q.push_back(store);
    exp_ex_q.push_back(mis || fault);
    exp_cause_q.push_back(cause);
  endtask

  // --------------------
  // request and response
  // --------------------
  task automatic drive_req(input op_t op, input addr_t base, input xlen_t imm,
                           input xlen_t wdata, input trans_id_t id);
    predict(op, base + imm, wdata, id);
    req_valid_i    = 1'b1;
    req_op_i       = op;
    req_base_i     = base;
    req_imm_i      = imm;
    req_wdata_i    = wdata;
    req_trans_id_i = id;
  endtask

  task automatic wait_accept();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!req_ready_o) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        fail_run("timeout while waiting for the DUT to accept a request");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic receive();
    int        cycles;
    trans_id_t exp_id;
    xlen_t     exp_rdata;
    logic      exp_store;
    logic      exp_ex;
    cause_t    exp_cause;
    if (exp_id_q.size() == 0) begin
      fail_run("a response was awaited but no request is outstanding");
    end
    exp_id    = exp_id_q.pop_front();
    exp_rdata = exp_rdata_q.pop_front();
    exp_store = exp_store_q.pop_front();
    exp_ex    = exp_ex_q.pop_front();
    exp_cause = exp_cause_q.pop_front();
    resp_ready_i = 1'b1;
    cycles = 0;
    @(negedge clk_i);
    while (!resp_valid_o) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        fail_run("timeout while waiting for a response from the DUT");
      end
      @(negedge clk_i);
    end
    check_id("resp_trans_id_o", exp_id, resp_trans_id_o);
    check_flag("resp_is_store_o", exp_store, resp_is_store_o);
    check_flag("resp_ex_valid_o", exp_ex, resp_ex_valid_o);
    if (exp_ex) begin
      check_cause("resp_ex_cause_o", exp_cause, resp_ex_cause_o);
    end
    check_data("resp_rdata_o", exp_rdata, resp_rdata_o);
    @(posedge clk_i);
    #1;
    resp_ready_i = 1'b0;
  endtask

  // one request and its response, random id
  task automatic access(input op_t op, input addr_t base, input xlen_t imm,
                        input xlen_t wdata);
    drive_req(op, base, imm, wdata, trans_id_t'($urandom));
    wait_accept();
    receive();
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic test_word_round_trip();
    addr_t a;
    a = addr_t'(($urandom % MEM_WORDS) * 4);
    access(OP_SW, a, '0, $urandom);
    access(OP_LW, a, '0, '0);
  endtask

  task automatic test_sub_word();
    addr_t a;
    a = 32'h0000_0040;
    repeat (2) begin
      access(OP_SW, a, '0, $urandom);
      // each partial store is read back before the next one covers it
      for (int unsigned o = 0; o < 4; o++) begin
        access(OP_SB, a, xlen_t'(o), $urandom);
        access(OP_LW, a, '0, '0);
      end
      for (int unsigned o = 0; o < 4; o += 2) begin
        access(OP_SH, a, xlen_t'(o), $urandom);
        access(OP_LW, a, '0, '0);
      end
      for (int unsigned o = 0; o < 4; o++) begin
        access(OP_LB, a, xlen_t'(o), '0);
        access(OP_LBU, a, xlen_t'(o), '0);
      end
      for (int unsigned o = 0; o < 4; o += 2) begin
        access(OP_LH, a, xlen_t'(o), '0);
        access(OP_LHU, a, xlen_t'(o), '0);
      end
    end
  endtask

  task automatic test_addr_arith();
    // negative immediates reach words 40 and 63
    access(OP_SW, 32'h0000_00A0, '0, $urandom);
    access(OP_LW, 32'h0000_01A0, 32'hFFFF_FF00, '0);
    access(OP_SW, 32'h0000_0100, 32'hFFFF_FFFC, $urandom);
    access(OP_LW, 32'h0000_00FC, '0, '0);
  endtask

  task automatic test_misaligned();
    addr_t a;
    a = 32'h0000_0020;
    access(OP_SW, a, '0, $urandom);
    access(OP_LH, a, 32'd1, '0);
    access(OP_LW, a, 32'd2, '0);
    access(OP_SH, a, 32'd3, $urandom);
    access(OP_SW, a, 32'd1, $urandom);
    access(OP_LW, a, '0, '0);
  endtask

  task automatic test_access_fault();
    addr_t a;
    a = addr_t'(MEM_WORDS * 4);
    access(OP_LW, a, '0, '0);
    access(OP_SW, a, 32'd20, $urandom);
    // low index bits of the faulting store point at word 5
    access(OP_LW, 32'h0000_0014, '0, '0);
    access(OP_LB, 32'hFFFF_FFF0, 32'd3, '0);
    // out of range and misaligned together
    access(OP_SH, a, 32'd1, $urandom);
    access(OP_LW, a, 32'd6, '0);
  endtask

  task automatic test_backpressure();
    int unsigned accepted;
    logic        stalled;
    addr_t       a;
    accepted = 0;
    stalled  = 1'b0;
    // responses stay blocked, fill agu stage, queue and memory stage
    while (!stalled) begin
      if (accepted >= MAX_BURST) begin
        fail_run("req_ready_o never fell while responses were blocked");
      end
      a = addr_t'((accepted / 2 + 8) * 4);
      if (accepted % 2 == 0) begin
        drive_req(OP_SW, a, '0, $urandom, trans_id_t'(accepted));
      end else begin
        drive_req(OP_LW, a, '0, '0, trans_id_t'(accepted));
      end
      @(negedge clk_i);
      if (req_ready_o) begin
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
        accepted++;
      end else begin
        stalled = 1'b1;
      end
    end
    if (accepted != FIFO_DEPTH + 2) begin
      fail_run($sformatf("pipeline stalled after %0d requests instead of %0d",
                         accepted, FIFO_DEPTH + 2));
    end
    @(posedge clk_i);
    #1;
    fork
      wait_accept();
      receive();
    join
    while (exp_id_q.size() != 0) begin
      receive();
    end
    // no extra response may follow
    repeat (4) @(negedge clk_i);
    check_flag("resp_valid_o", 1'b0, resp_valid_o);
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    void'($urandom(SEED));
    for (int unsigned w = 0; w < MEM_WORDS; w++) begin
      ref_mem[w] = '0;
    end
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_op_i       = OP_LW;
    req_base_i     = '0;
    req_imm_i      = '0;
    req_wdata_i    = '0;
    req_trans_id_i = '0;
    resp_ready_i   = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    test_word_round_trip();
    test_sub_word();
    test_addr_arith();
    test_misaligned();
    test_access_fault();
    test_backpressure();
    if (exp_id_q.size() != 0) begin
      fail_run("requests are left without a response at the end of the run");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// ==== dv/lsu_top_assert.sv ====
/*
  Handshake assertions for the load/store unit top level.
  Bound into lsu_top, checks request ready after reset and the
  response hold rules of the valid/ready port.
*/

`timescale 1ns/1ps

module lsu_top_assert (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                req_ready_o,
  input logic                resp_valid_o,
  input lsu_pkg::trans_id_t  resp_trans_id_o,
  input lsu_pkg::xlen_t      resp_rdata_o,
  input logic                resp_is_store_o,
  input logic                resp_ex_valid_o,
  input lsu_pkg::cause_t     resp_ex_cause_o,
  input logic                resp_ready_i
);

  // empty pipeline takes a request right after reset
  a_ready_after_reset: assert property (
    @(posedge clk_i) $rose(rst_ni) |-> req_ready_o
  ) else $error("req_ready_o is low in the first cycle after reset");

  // a blocked response keeps its fields
  a_resp_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && !resp_ready_i |=> $stable({resp_trans_id_o, resp_rdata_o,
      resp_is_store_o, resp_ex_valid_o, resp_ex_cause_o})
  ) else $error("response fields changed while the response was blocked");

  a_resp_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && !resp_ready_i |=> resp_valid_o
  ) else $error("resp_valid_o fell without a transfer");

endmodule

bind lsu_top lsu_top_assert u_assert (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .req_ready_o     (req_ready_o),
  .resp_valid_o    (resp_valid_o),
  .resp_trans_id_o (resp_trans_id_o),
  .resp_rdata_o    (resp_rdata_o),
  .resp_is_store_o (resp_is_store_o),
  .resp_ex_valid_o (resp_ex_valid_o),
  .resp_ex_cause_o (resp_ex_cause_o),
  .resp_ready_i    (resp_ready_i)
);

// ==== source/lsu_top.sv ====
/*
  Top level of the load/store unit.
  Chains address generation, the request queue and the memory access
  stage with valid/ready handshakes and passes the sizes down.
*/

`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned MEM_WORDS  = lsu_pkg::DEFAULT_MEM_WORDS,
  parameter int unsigned FIFO_DEPTH = lsu_pkg::DEFAULT_FIFO_DEPTH
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  input  lsu_pkg::op_t        req_op_i,
  input  lsu_pkg::addr_t      req_base_i,
  input  lsu_pkg::xlen_t      req_imm_i,
  input  lsu_pkg::xlen_t      req_wdata_i,
  input  lsu_pkg::trans_id_t  req_trans_id_i,
  output logic                req_ready_o,
  output logic                resp_valid_o,
  output lsu_pkg::trans_id_t  resp_trans_id_o,
  output lsu_pkg::xlen_t      resp_rdata_o,
  output logic                resp_is_store_o,
  output logic                resp_ex_valid_o,
  output lsu_pkg::cause_t     resp_ex_cause_o,
  input  logic                resp_ready_i
);
  import lsu_pkg::*;

  // --------------------
  // agu to queue
  // --------------------
  logic      agu_valid;
  logic      agu_ready;
  op_t       agu_op;
  addr_t     agu_addr;
  xlen_t     agu_wdata;
  be_t       agu_be;
  trans_id_t agu_trans_id;
  logic      agu_ex_valid;
  cause_t    agu_ex_cause;

  // --------------------
  // queue to memory
  // --------------------
  logic      q_valid;
  logic      q_ready;
  op_t       q_op;
  addr_t     q_addr;
  xlen_t     q_wdata;
  be_t       q_be;
  trans_id_t q_trans_id;
  logic      q_ex_valid;
  cause_t    q_ex_cause;

  lsu_agu #(
    .MEM_WORDS(MEM_WORDS)
  ) u_agu (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_op_i       (req_op_i),
    .req_base_i     (req_base_i),
    .req_imm_i      (req_imm_i),
    .req_wdata_i    (req_wdata_i),
    .req_trans_id_i (req_trans_id_i),
    .req_ready_o    (req_ready_o),
    .agu_valid_o    (agu_valid),
    .agu_op_o       (agu_op),
    .agu_addr_o     (agu_addr),
    .agu_wdata_o    (agu_wdata),
    .agu_be_o       (agu_be),
    .agu_trans_id_o (agu_trans_id),
    .agu_ex_valid_o (agu_ex_valid),
    .agu_ex_cause_o (agu_ex_cause),
    .agu_ready_i    (agu_ready)
  );

  lsu_req_fifo #(
    .DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wr_valid_i    (agu_valid),
    .wr_op_i       (agu_op),
    .wr_addr_i     (agu_addr),
    .wr_wdata_i    (agu_wdata),
    .wr_be_i       (agu_be),
    .wr_trans_id_i (agu_trans_id),
    .wr_ex_valid_i (agu_ex_valid),
    .wr_ex_cause_i (agu_ex_cause),
    .wr_ready_o    (agu_ready),
    .rd_valid_o    (q_valid),
    .rd_op_o       (q_op),
    .rd_addr_o     (q_addr),
    .rd_wdata_o    (q_wdata),
    .rd_be_o       (q_be),
    .rd_trans_id_o (q_trans_id),
    .rd_ex_valid_o (q_ex_valid),
    .rd_ex_cause_o (q_ex_cause),
    .rd_ready_i    (q_ready)
  );

  lsu_mem_unit #(
    .MEM_WORDS(MEM_WORDS)
  ) u_mem (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .q_valid_i       (q_valid),
    .q_op_i          (q_op),
    .q_addr_i        (q_addr),
    .q_wdata_i       (q_wdata),
    .q_be_i          (q_be),
    .q_trans_id_i    (q_trans_id),
    .q_ex_valid_i    (q_ex_valid),
    .q_ex_cause_i    (q_ex_cause),
    .q_ready_o       (q_ready),
    .resp_valid_o    (resp_valid_o),
    .resp_trans_id_o (resp_trans_id_o),
    .resp_rdata_o    (resp_rdata_o),
    .resp_is_store_o (resp_is_store_o),
    .resp_ex_valid_o (resp_ex_valid_o),
    .resp_ex_cause_o (resp_ex_cause_o),
    .resp_ready_i    (resp_ready_i)
  );

endmodule

// ==== source/lsu_mem_unit.sv ====
/*
  Memory access stage of the load/store unit.
  Owns the word-organized data RAM, merges stores under byte enables and
  extracts and extends load data. One access at a time, its response is
  held in a register until the consumer takes it.
*/

`timescale 1ns/1ps

module lsu_mem_unit #(
  parameter int unsigned MEM_WORDS = lsu_pkg::DEFAULT_MEM_WORDS
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                q_valid_i,
  input  lsu_pkg::op_t        q_op_i,
  input  lsu_pkg::addr_t      q_addr_i,
  input  lsu_pkg::xlen_t      q_wdata_i,
  input  lsu_pkg::be_t        q_be_i,
  input  lsu_pkg::trans_id_t  q_trans_id_i,
  input  logic                q_ex_valid_i,
  input  lsu_pkg::cause_t     q_ex_cause_i,
  output logic                q_ready_o,
  output logic                resp_valid_o,
  output lsu_pkg::trans_id_t  resp_trans_id_o,
  output lsu_pkg::xlen_t      resp_rdata_o,
  output logic                resp_is_store_o,
  output logic                resp_ex_valid_o,
  output lsu_pkg::cause_t     resp_ex_cause_o,
  input  logic                resp_ready_i
);
  import lsu_pkg::*;

  localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  typedef enum logic [0:0] {
    ST_IDLE,
    ST_RESP
  } state_e;

  state_e           state_q;
  xlen_t            ram [MEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             accept;
  logic             is_store;
  xlen_t            word;
  xlen_t            shifted;
  xlen_t            load_data;

  assign q_ready_o    = (state_q == ST_IDLE);
  assign resp_valid_o = (state_q == ST_RESP);
  assign accept       = q_valid_i && q_ready_o;
  assign is_store     = is_store_op(q_op_i);

  // range is checked upstream, faulting requests never index the RAM
  assign idx = q_addr_i[IDX_W+1:2];

  // --------------------
  // load extraction
  // --------------------
  assign word    = ram[idx];
  assign shifted = word >> {q_addr_i[1:0], 3'b000};

  always_comb begin : load_extend
    case (q_op_i)
      OP_LB:   load_data = {{24{shifted[7]}}, shifted[7:0]};
      OP_LBU:  load_data = {24'h0, shifted[7:0]};
      OP_LH:   load_data = {{16{shifted[15]}}, shifted[15:0]};
      OP_LHU:  load_data = {16'h0, shifted[15:0]};
      default: load_data = word;
    endcase
  end

  // --------------------
  // state machine
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (q_valid_i) state_q <= ST_RESP;
        ST_RESP: if (resp_ready_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // RAM comes up cleared, stores merge byte by byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < int'(MEM_WORDS); w++) begin
        ram[w] <= '0;
      end
    end else if (accept && is_store && !q_ex_valid_i) begin
      for (int b = 0; b < 4; b++) begin
        if (q_be_i[b]) begin
          ram[idx][8*b +: 8] <= q_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // response register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_trans_id_o <= q_trans_id_i;
      resp_is_store_o <= is_store;
      resp_ex_valid_o <= q_ex_valid_i;
      resp_ex_cause_o <= q_ex_cause_i;
      resp_rdata_o    <= (is_store || q_ex_valid_i) ? '0 : load_data;
    end
  end

endmodule

// ==== source/lsu_req_fifo.sv ====
/*
  Request queue between address generation and memory access.
  Circular buffer of DEPTH decoded requests with an occupancy count.
  A push and a pop may happen in the same cycle, also when full.
*/

`timescale 1ns/1ps

module lsu_req_fifo #(
  parameter int unsigned DEPTH = lsu_pkg::DEFAULT_FIFO_DEPTH
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                wr_valid_i,
  input  lsu_pkg::op_t        wr_op_i,
  input  lsu_pkg::addr_t      wr_addr_i,
  input  lsu_pkg::xlen_t      wr_wdata_i,
  input  lsu_pkg::be_t        wr_be_i,
  input  lsu_pkg::trans_id_t  wr_trans_id_i,
  input  logic                wr_ex_valid_i,
  input  lsu_pkg::cause_t     wr_ex_cause_i,
  output logic                wr_ready_o,
  output logic                rd_valid_o,
  output lsu_pkg::op_t        rd_op_o,
  output lsu_pkg::addr_t      rd_addr_o,
  output lsu_pkg::xlen_t      rd_wdata_o,
  output lsu_pkg::be_t        rd_be_o,
  output lsu_pkg::trans_id_t  rd_trans_id_o,
  output logic                rd_ex_valid_o,
  output lsu_pkg::cause_t     rd_ex_cause_o,
  input  logic                rd_ready_i
);
  import lsu_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  op_t       op_mem       [DEPTH];
  addr_t     addr_mem     [DEPTH];
  xlen_t     wdata_mem    [DEPTH];
  be_t       be_mem       [DEPTH];
  trans_id_t trans_id_mem [DEPTH];
  logic      ex_valid_mem [DEPTH];
  cause_t    ex_cause_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // wrap at DEPTH, not only at powers of two
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign rd_valid_o = (count_q != '0);
  assign wr_ready_o = (count_q != CNT_W'(DEPTH)) || rd_ready_i;
  assign push       = wr_valid_i && wr_ready_o;
  assign pop        = rd_valid_o && rd_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      op_mem[wr_ptr_q]       <= wr_op_i;
      addr_mem[wr_ptr_q]     <= wr_addr_i;
      wdata_mem[wr_ptr_q]    <= wr_wdata_i;
      be_mem[wr_ptr_q]       <= wr_be_i;
      trans_id_mem[wr_ptr_q] <= wr_trans_id_i;
      ex_valid_mem[wr_ptr_q] <= wr_ex_valid_i;
      ex_cause_mem[wr_ptr_q] <= wr_ex_cause_i;
    end
  end

  assign rd_op_o       = op_mem[rd_ptr_q];
  assign rd_addr_o     = addr_mem[rd_ptr_q];
  assign rd_wdata_o    = wdata_mem[rd_ptr_q];
  assign rd_be_o       = be_mem[rd_ptr_q];
  assign rd_trans_id_o = trans_id_mem[rd_ptr_q];
  assign rd_ex_valid_o = ex_valid_mem[rd_ptr_q];
  assign rd_ex_cause_o = ex_cause_mem[rd_ptr_q];

endmodule

// ==== source/lsu_agu.sv ====
/*
  Address generation stage of the load/store unit.
  Adds base and signed immediate, builds byte enables, moves store data
  into its byte lanes and flags misaligned or out-of-range accesses.
  The result sits in a one-entry output register with valid/ready handshake.
*/

`timescale 1ns/1ps

module lsu_agu #(
  parameter int unsigned MEM_WORDS = lsu_pkg::DEFAULT_MEM_WORDS
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  input  lsu_pkg::op_t        req_op_i,
  input  lsu_pkg::addr_t      req_base_i,
  input  lsu_pkg::xlen_t      req_imm_i,
  input  lsu_pkg::xlen_t      req_wdata_i,
  input  lsu_pkg::trans_id_t  req_trans_id_i,
  output logic                req_ready_o,
  output logic                agu_valid_o,
  output lsu_pkg::op_t        agu_op_o,
  output lsu_pkg::addr_t      agu_addr_o,
  output lsu_pkg::xlen_t      agu_wdata_o,
  output lsu_pkg::be_t        agu_be_o,
  output lsu_pkg::trans_id_t  agu_trans_id_o,
  output logic                agu_ex_valid_o,
  output lsu_pkg::cause_t     agu_ex_cause_o,
  input  logic                agu_ready_i
);
  import lsu_pkg::*;

  addr_t  eff_addr;
  logic   is_store;
  logic   is_byte;
  logic   is_half;
  be_t    be;
  xlen_t  wdata_lanes;
  logic   misaligned;
  logic   out_of_range;
  cause_t ex_cause;

  // modulo 2^32, the sum is the same for a signed immediate
  assign eff_addr = req_base_i + req_imm_i;
  assign is_store = is_store_op(req_op_i);

  // transfer size from the op code
  assign is_byte = (req_op_i == OP_LB) || (req_op_i == OP_LBU) || (req_op_i == OP_SB);
  assign is_half = (req_op_i == OP_LH) || (req_op_i == OP_LHU) || (req_op_i == OP_SH);

  // --------------------
  // byte enables and lanes
  // --------------------
  always_comb begin : be_gen
    if (is_byte) begin
      be = be_t'(4'b0001 << eff_addr[1:0]);
    end else if (is_half) begin
      be = be_t'(4'b0011 << eff_addr[1:0]);
    end else begin
      be = 4'b1111;
    end
  end

  assign wdata_lanes = req_wdata_i << {eff_addr[1:0], 3'b000};

  // --------------------
  // exception detection
  // --------------------
  assign misaligned = is_half ? eff_addr[0] :
                      is_byte ? 1'b0 : (eff_addr[1:0] != 2'b00);
  assign out_of_range = {2'b00, eff_addr[31:2]} >= MEM_WORDS;

  // misalignment wins over the access fault
  always_comb begin : cause_sel
    if (misaligned) begin
      ex_cause = is_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
    end else begin
      ex_cause = is_store ? CAUSE_ST_ACCESS_FAULT : CAUSE_LD_ACCESS_FAULT;
    end
  end

  // stage takes a new request when empty or draining
  assign req_ready_o = !agu_valid_o || agu_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      agu_valid_o <= 1'b0;
    end else if (req_ready_o) begin
      agu_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      agu_op_o       <= req_op_i;
      agu_addr_o     <= eff_addr;
      agu_wdata_o    <= wdata_lanes;
      agu_be_o       <= be;
      agu_trans_id_o <= req_trans_id_i;
      agu_ex_valid_o <= misaligned || out_of_range;
      agu_ex_cause_o <= ex_cause;
    end
  end

endmodule

// ==== source/lsu_pkg.sv ====
/*
  Shared definitions for the load/store unit.
  Holds the data, address and id widths, the operation codes, the
  exception causes and the default sizes that the top level passes down.
  Modules import it inside their body and use scoped names in their headers.
*/

package lsu_pkg;

  // --------------------
  // widths
  // --------------------
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  be_t;
  typedef logic [2:0]  trans_id_t;
  typedef logic [3:0]  op_t;
  typedef logic [3:0]  cause_t;

  // --------------------
  // operation codes
  // --------------------
  // bit 3 set marks a store, unknown codes behave as a word load
  localparam op_t OP_LB  = 4'h0;
  localparam op_t OP_LBU = 4'h1;
  localparam op_t OP_LH  = 4'h2;
  localparam op_t OP_LHU = 4'h3;
  localparam op_t OP_LW  = 4'h4;
  localparam op_t OP_SB  = 4'h8;
  localparam op_t OP_SH  = 4'h9;
  localparam op_t OP_SW  = 4'hA;

  // riscv mcause encodings
  localparam cause_t CAUSE_LD_MISALIGNED   = 4'd4;
  localparam cause_t CAUSE_LD_ACCESS_FAULT = 4'd5;
  localparam cause_t CAUSE_ST_MISALIGNED   = 4'd6;
  localparam cause_t CAUSE_ST_ACCESS_FAULT = 4'd7;

  // default sizes
  localparam int unsigned DEFAULT_MEM_WORDS  = 64;
  localparam int unsigned DEFAULT_FIFO_DEPTH = 4;

  // only the three store codes write memory
  function automatic logic is_store_op(op_t op);
    return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
  endfunction

endpackage
